// ==== build.f ====
complex_pkg.sv
complex_alu.sv
issue_latch.sv
result_delay_pipe.sv
complex_exec_lane.sv
complex_exec_assertions.sv
tb_complex_exec_lane.sv

// ==== complex_alu.sv ====
/*
  complex ALU
  combinational signed/unsigned multiply, divide and syscall unit
  with defined divide-by-zero and overflow results, plus flag word
*/
`timescale 1ns/100ps

module complex_alu (
  input  logic [complex_pkg::opcode_w-1:0] opcode_i, // decoded opcode
  input  logic [complex_pkg::data_w-1:0]   data1_i,  // source a / dividend
  input  logic [complex_pkg::data_w-1:0]   data2_i,  // source b / divisor
  output logic [complex_pkg::data_w-1:0]   result_o, // selected word
  output logic [complex_pkg::flags_w-1:0]  flags_o   // execution flags
);

  localparam int dw = complex_pkg::data_w;
  localparam logic [dw-1:0] min_s = {1'b1, {(dw-1){1'b0}}}; // most negative value
  localparam logic [dw-1:0] one_w = dw'(1);

  logic signed [2*dw-1:0] prod_s; // full signed product
  logic        [2*dw-1:0] prod_u; // full unsigned product
  logic                   div_zero; // divisor is zero
  logic                   div_ovf;  // min / -1
  logic        [dw-1:0]   dvs_s;    // safe signed divisor
  logic        [dw-1:0]   dvs_u;    // safe unsigned divisor
  logic signed [dw-1:0]   quo_s;
  logic signed [dw-1:0]   rem_s;
  logic        [dw-1:0]   quo_u;
  logic        [dw-1:0]   rem_u;
  logic        [dw-1:0]   div_q;  // signed quotient, defined cases applied
  logic        [dw-1:0]   div_r;  // signed remainder
  logic        [dw-1:0]   divu_q; // unsigned quotient
  logic        [dw-1:0]   divu_r; // unsigned remainder

  // explicit extension to 2*dw so no context rules are involved
  assign prod_s = $signed({{dw{data1_i[dw-1]}}, data1_i}) *
                  $signed({{dw{data2_i[dw-1]}}, data2_i});
  assign prod_u = {{dw{1'b0}}, data1_i} * {{dw{1'b0}}, data2_i};

  assign div_zero = (data2_i == '0);
  assign div_ovf  = (data1_i == min_s) && (data2_i == '1);

  // dividing by one in the overflow case gives min and 0, which is the defined answer
  assign dvs_s = (div_zero || div_ovf) ? one_w : data2_i;
  assign dvs_u = div_zero ? one_w : data2_i;

  assign quo_s = $signed(data1_i) / $signed(dvs_s);
  assign rem_s = $signed(data1_i) % $signed(dvs_s); // sign follows dividend
  assign quo_u = data1_i / dvs_u;
  assign rem_u = data1_i % dvs_u;

  assign div_q  = div_zero ? '1 : quo_s;      // x/0 -> all ones
  assign div_r  = div_zero ? data1_i : rem_s; // x%0 -> dividend
  assign divu_q = div_zero ? '1 : quo_u;
  assign divu_r = div_zero ? data1_i : rem_u;

  // result word select
  always_comb begin
    case (opcode_i)
      complex_pkg::op_mult_l:  result_o = prod_s[dw-1:0];
      complex_pkg::op_mult_h:  result_o = prod_s[2*dw-1:dw];
      complex_pkg::op_multu_l: result_o = prod_u[dw-1:0];
      complex_pkg::op_multu_h: result_o = prod_u[2*dw-1:dw];
      complex_pkg::op_div_l:   result_o = div_q;
      complex_pkg::op_div_h:   result_o = div_r;
      complex_pkg::op_divu_l:  result_o = divu_q;
      complex_pkg::op_divu_h:  result_o = divu_r;
      default:                 result_o = '0; // syscall and unknown opcodes
    endcase
  end

  // flag word
  always_comb begin
    flags_o = '0;
    case (opcode_i)
      complex_pkg::op_mult_l, complex_pkg::op_multu_l,
      complex_pkg::op_div_l,  complex_pkg::op_divu_l: begin
        flags_o[complex_pkg::flg_dest_valid] = 1'b1;
        flags_o[complex_pkg::flg_lo_half]    = 1'b1; // L forms only
        flags_o[complex_pkg::flg_executed]   = 1'b1;
      end
      complex_pkg::op_mult_h, complex_pkg::op_multu_h,
      complex_pkg::op_div_h,  complex_pkg::op_divu_h: begin
        flags_o[complex_pkg::flg_dest_valid] = 1'b1;
        flags_o[complex_pkg::flg_executed]   = 1'b1;
      end
      complex_pkg::op_syscall: begin
        flags_o[complex_pkg::flg_executed]  = 1'b1;
        flags_o[complex_pkg::flg_exception] = 1'b1; // trap taken at retire
      end
      default: flags_o = '0; // unknown opcode still writes back, all clear
    endcase
    flags_o[complex_pkg::flg_branch]     = 1'b0; // no control transfer here
    flags_o[complex_pkg::flg_mispredict] = 1'b0;
  end

endmodule

// ==== complex_exec_assertions.sv ====
/*
  complex execution lane checker
  concurrent assertions on write-back timing, flush kill,
  unused flag bits and reset, bound into complex_exec_lane
*/
`timescale 1ns/100ps

module complex_exec_assertions #(
  parameter int LATENCY = 4 // issue to writeback edges
) (
  input logic                            clk_i,
  input logic                            arst_n_i,
  input logic                            issue_valid_i,
  input logic                            flush_i,
  input logic                            wb_valid_i,
  input logic [complex_pkg::flags_w-1:0] wb_flags_i
);

  int                 fail_cnt = 0; // failures so far
  logic [LATENCY-2:0] flush_hist;   // flush seen at the last LATENCY-1 edges, [0] newest

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      flush_hist <= '0;
    end else begin
      flush_hist <= (flush_hist << 1) | (LATENCY-1)'(flush_i);
    end
  end

  // accepted issue with no later flush must write back now
  wb_on_time: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ($past(issue_valid_i && !flush_i, LATENCY) && !(|flush_hist)) |-> wb_valid_i)
    else begin
      fail_cnt++;
      $error("accepted issue gave no write-back LATENCY edges later");
    end

  // a write-back always traces back to a surviving issue
  wb_has_issue: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_valid_i |-> ($past(issue_valid_i && !flush_i, LATENCY) && !(|flush_hist)))
    else begin
      fail_cnt++;
      $error("write-back without a matching accepted issue");
    end

  wb_flags_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_valid_i |-> (!wb_flags_i[complex_pkg::flg_branch] &&
                    !wb_flags_i[complex_pkg::flg_mispredict]))
    else begin
      fail_cnt++;
      $error("branch or mispredict flag set on write-back");
    end

  wb_quiet_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !wb_valid_i)
    else begin
      fail_cnt++;
      $error("write-back valid while reset is asserted");
    end

endmodule

bind complex_exec_lane complex_exec_assertions #(.LATENCY(LATENCY)) u_complex_exec_assertions (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .issue_valid_i (issue_valid_i),
  .flush_i       (flush_i),
  .wb_valid_i    (wb_valid_o),
  .wb_flags_i    (wb_flags_o)
);

// ==== complex_exec_lane.sv ====
/*
  complex execution lane
  issue latch, mult/div ALU and a LATENCY-1 deep result pipe,
  one instruction per cycle, writeback exactly LATENCY edges after issue
*/
`timescale 1ns/100ps

module complex_exec_lane #(
  parameter int LATENCY = 4 // issue to writeback, 2 or more
) (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             issue_valid_i,
  input  logic [complex_pkg::opcode_w-1:0] issue_opcode_i,
  input  logic [complex_pkg::data_w-1:0]   issue_data1_i,
  input  logic [complex_pkg::data_w-1:0]   issue_data2_i,
  input  logic [complex_pkg::tag_w-1:0]    issue_tag_i,
  input  logic                             flush_i,     // squash everything in flight
  output logic                             wb_valid_o,
  output logic [complex_pkg::data_w-1:0]   wb_result_o,
  output logic [complex_pkg::flags_w-1:0]  wb_flags_o,
  output logic [complex_pkg::tag_w-1:0]    wb_tag_o
);

  typedef logic [complex_pkg::data_w+complex_pkg::flags_w-1:0] res_pay_t; // {result, flags}
  typedef logic [complex_pkg::tag_w-1:0]                       tag_pay_t;

  logic                             lat_valid;
  logic [complex_pkg::opcode_w-1:0] lat_opcode;
  logic [complex_pkg::data_w-1:0]   lat_data1;
  logic [complex_pkg::data_w-1:0]   lat_data2;
  logic [complex_pkg::tag_w-1:0]    lat_tag;
  logic [complex_pkg::data_w-1:0]   alu_result;
  logic [complex_pkg::flags_w-1:0]  alu_flags;
  res_pay_t                         res_out; // pipe output before unpacking

  issue_latch u_issue_latch (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .flush_i  (flush_i),
    .valid_i  (issue_valid_i),
    .opcode_i (issue_opcode_i),
    .data1_i  (issue_data1_i),
    .data2_i  (issue_data2_i),
    .tag_i    (issue_tag_i),
    .valid_o  (lat_valid),
    .opcode_o (lat_opcode),
    .data1_o  (lat_data1),
    .data2_o  (lat_data2),
    .tag_o    (lat_tag)
  );

  complex_alu u_alu (
    .opcode_i (lat_opcode),
    .data1_i  (lat_data1),
    .data2_i  (lat_data2),
    .result_o (alu_result),
    .flags_o  (alu_flags)
  );

  // latch takes one edge, pipes take the rest
  result_delay_pipe #(.DEPTH(LATENCY-1), .payload_t(res_pay_t)) u_res_pipe (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .flush_i       (flush_i),
    .in_valid_i    (lat_valid),
    .in_payload_i  ({alu_result, alu_flags}),
    .out_valid_o   (wb_valid_o),
    .out_payload_o (res_out)
  );

  result_delay_pipe #(.DEPTH(LATENCY-1), .payload_t(tag_pay_t)) u_tag_pipe (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .flush_i       (flush_i),
    .in_valid_i    (lat_valid),
    .in_payload_i  (lat_tag),
    .out_valid_o   (),          // same as u_res_pipe valid
    .out_payload_o (wb_tag_o)
  );

  assign {wb_result_o, wb_flags_o} = res_out;

endmodule

// ==== complex_pkg.sv ====
/*
  complex execution lane shared definitions
  data and tag widths, opcode codes of the mult/div/syscall group
  and bit positions inside the execution flag word
*/
package complex_pkg;

  // widths
  localparam int data_w   = 32; // operand and result width
  localparam int tag_w    = 7;  // physical register tag
  localparam int opcode_w = 8;  // instruction opcode
  localparam int flags_w  = 6;  // execution flag word

  // multiply opcodes, L is low word and H is high word of the product
  localparam logic [opcode_w-1:0] op_mult_l  = 8'h48; // signed, low half
  localparam logic [opcode_w-1:0] op_mult_h  = 8'h49; // signed, high half
  localparam logic [opcode_w-1:0] op_multu_l = 8'h4a; // unsigned, low half
  localparam logic [opcode_w-1:0] op_multu_h = 8'h4b; // unsigned, high half

  // divide opcodes, L gives the quotient and H the remainder
  localparam logic [opcode_w-1:0] op_div_l   = 8'h4c; // signed quotient
  localparam logic [opcode_w-1:0] op_div_h   = 8'h4d; // signed remainder
  localparam logic [opcode_w-1:0] op_divu_l  = 8'h4e; // unsigned quotient
  localparam logic [opcode_w-1:0] op_divu_h  = 8'h4f; // unsigned remainder

  // trap to the OS, no destination write
  localparam logic [opcode_w-1:0] op_syscall = 8'ha0;

  // flag word bit positions, msb first
  localparam int flg_branch     = 5; // never set by this lane
  localparam int flg_dest_valid = 4; // result goes to the destination reg
  localparam int flg_lo_half    = 3; // low half / quotient was picked
  localparam int flg_executed   = 2; // instruction completed
  localparam int flg_exception  = 1; // raise exception at retire
  localparam int flg_mispredict = 0; // never set by this lane

endpackage

// ==== issue_latch.sv ====
/*
  issue latch
  registers an issued instruction in front of the complex ALU,
  valid bit cleared by reset and by flush
*/
`timescale 1ns/100ps

module issue_latch (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            flush_i,  // kill incoming and held op
  input  logic                            valid_i,
  input  logic [complex_pkg::opcode_w-1:0] opcode_i,
  input  logic [complex_pkg::data_w-1:0]   data1_i,
  input  logic [complex_pkg::data_w-1:0]   data2_i,
  input  logic [complex_pkg::tag_w-1:0]    tag_i,
  output logic                            valid_o,
  output logic [complex_pkg::opcode_w-1:0] opcode_o,
  output logic [complex_pkg::data_w-1:0]   data1_o,
  output logic [complex_pkg::data_w-1:0]   data2_o,
  output logic [complex_pkg::tag_w-1:0]    tag_o
);

  // valid tracks the issue strobe one cycle later
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
    end else if (flush_i) begin
      valid_o <= 1'b0; // same-cycle issue dies too
    end else begin
      valid_o <= valid_i;
    end
  end

  // payload only moves on a real issue, holds otherwise
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      opcode_o <= opcode_i;
      data1_o  <= data1_i;
      data2_o  <= data2_i;
      tag_o    <= tag_i; // dest phys reg
    end
  end

endmodule

// ==== result_delay_pipe.sv ====
/*
  result delay pipe
  DEPTH-stage valid-tracked shift register for any payload type,
  flush clears every stage valid
*/
`timescale 1ns/100ps

module result_delay_pipe #(
  parameter int  DEPTH     = 3,    // stages, 1 or more
  parameter type payload_t = logic // carried word
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     flush_i,      // kill all in flight
  input  logic     in_valid_i,
  input  payload_t in_payload_i,
  output logic     out_valid_o,
  output payload_t out_payload_o
);

  logic [DEPTH-1:0] vld_q;          // per-stage valid, [0] is newest
  payload_t         pay_q [DEPTH];  // per-stage payload

  // valid chain
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vld_q <= '0;
    end else if (flush_i) begin
      vld_q <= '0; // everything in flight is dropped
    end else begin
      vld_q[0] <= in_valid_i;
      for (int i = 1; i < DEPTH; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  // payload chain, a stage loads only behind a valid entry
  always_ff @(posedge clk_i) begin
    if (in_valid_i) begin
      pay_q[0] <= in_payload_i;
    end
    for (int i = 1; i < DEPTH; i++) begin
      if (vld_q[i-1]) begin
        pay_q[i] <= pay_q[i-1];
      end
    end
  end

  assign out_valid_o   = vld_q[DEPTH-1]; // oldest stage
  assign out_payload_o = pay_q[DEPTH-1];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the complex execution lane testbench with Verilator
# exit status 0 only when the run reports a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  --top-module tb_complex_exec_lane \
  -f build.f \
  -o sim_tb_complex_exec_lane
status=$?
if [ $status -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit 1
fi

# assertion errors must not stop the run before the testbench summary
out=$(./obj_dir/sim_tb_complex_exec_lane +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

// ==== tb_complex_exec_lane.sv ====
/*
  testbench for the complex execution lane
  LFSR operands, queue of expected write-backs built from the lane rules,
  one report line per test, timing assertions bound into the DUT
*/
`timescale 1ns/100ps

module tb_complex_exec_lane;

  localparam int LATENCY     = 4;
  localparam int stim_cycles = 24 + 60 + 36 + 6 + 40 + 8 + LATENCY + 6 * (LATENCY + 3);
  localparam int max_cycles  = stim_cycles + LATENCY + 50;

  typedef struct {
    logic [complex_pkg::data_w-1:0]  result;
    logic [complex_pkg::flags_w-1:0] flags;
    logic [complex_pkg::tag_w-1:0]   tag;
    int                              due; // cycle count when wb_valid_o is sampled high
  } wb_exp_t;

  logic                             clk = 1'b0;
  logic                             arst_n;
  logic                             issue_valid;
  logic [complex_pkg::opcode_w-1:0] issue_opcode;
  logic [complex_pkg::data_w-1:0]   issue_data1;
  logic [complex_pkg::data_w-1:0]   issue_data2;
  logic [complex_pkg::tag_w-1:0]    issue_tag;
  logic                             flush;
  logic                             wb_valid;
  logic [complex_pkg::data_w-1:0]   wb_result;
  logic [complex_pkg::flags_w-1:0]  wb_flags;
  logic [complex_pkg::tag_w-1:0]    wb_tag;

  wb_exp_t                       exp_q[$];         // in flight, oldest first
  int                            cyc = 0;          // rising edges seen
  int                            errors = 0;
  int                            checks = 0;
  int                            mark = 0;         // failures counted before this test
  int                            tests_run = 0;
  int                            tests_failed = 0;
  logic [31:0]                   lfsr_state = 32'h5821;
  logic [complex_pkg::tag_w-1:0] next_tag = '0;

  complex_exec_lane #(.LATENCY(LATENCY)) u_complex_exec_lane (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .issue_valid_i  (issue_valid),
    .issue_opcode_i (issue_opcode),
    .issue_data1_i  (issue_data1),
    .issue_data2_i  (issue_data2),
    .issue_tag_i    (issue_tag),
    .flush_i        (flush),
    .wb_valid_o     (wb_valid),
    .wb_result_o    (wb_result),
    .wb_flags_o     (wb_flags),
    .wb_tag_o       (wb_tag)
  );

  always #5 clk = ~clk; // 10 ns period

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // galois lfsr, one step per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  function automatic logic [31:0] edge_val(input int k);
    case (k)
      0:       return 32'h0000_0000;
      1:       return 32'hffff_ffff; // minus one
      default: return 32'h8000_0000; // signed minimum
    endcase
  endfunction

  function automatic logic [7:0] mix_op(input logic [3:0] k);
    case (k)
      4'd0, 4'd9:  return complex_pkg::op_mult_l;
      4'd1, 4'd10: return complex_pkg::op_mult_h;
      4'd2, 4'd11: return complex_pkg::op_multu_l;
      4'd3, 4'd12: return complex_pkg::op_multu_h;
      4'd4, 4'd13: return complex_pkg::op_div_l;
      4'd5, 4'd14: return complex_pkg::op_div_h;
      4'd6:        return complex_pkg::op_divu_l;
      4'd7:        return complex_pkg::op_divu_h;
      4'd8:        return complex_pkg::op_syscall;
      default:     return 8'h33; // not a lane opcode
    endcase
  endfunction

  // expected {result, flags} from the operation rules of the lane
  function automatic logic [complex_pkg::data_w+complex_pkg::flags_w-1:0] model_wb(
    input logic [7:0] op, input logic [31:0] a, input logic [31:0] b);
    longint      sa;
    longint      sb;
    logic [63:0] ps;
    logic [63:0] pu;
    logic [31:0] qs;
    logic [31:0] rs;
    logic [31:0] qu;
    logic [31:0] ru;
    logic [31:0] res;
    logic [5:0]  flg;
    sa = 64'($signed(a));
    sb = 64'($signed(b));
    ps = sa * sb;
    pu = {32'd0, a} * {32'd0, b};
    if (b == 32'd0) begin
      qs = '1; // quotient all ones, remainder is the dividend
      rs = a;
      qu = '1;
      ru = a;
    end else begin
      qu = a / b;
      ru = a % b;
      if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
        qs = a;
        rs = '0;
      end else begin
        qs = $signed(a) / $signed(b);
        rs = $signed(a) % $signed(b);
      end
    end
    flg = '0;
    case (op)
      complex_pkg::op_mult_l:  res = ps[31:0];
      complex_pkg::op_mult_h:  res = ps[63:32];
      complex_pkg::op_multu_l: res = pu[31:0];
      complex_pkg::op_multu_h: res = pu[63:32];
      complex_pkg::op_div_l:   res = qs;
      complex_pkg::op_div_h:   res = rs;
      complex_pkg::op_divu_l:  res = qu;
      complex_pkg::op_divu_h:  res = ru;
      default:                 res = '0;
    endcase
    if (op inside {[complex_pkg::op_mult_l:complex_pkg::op_divu_h]}) begin
      flg[complex_pkg::flg_dest_valid] = 1'b1;
      flg[complex_pkg::flg_executed]   = 1'b1;
    end
    if (op inside {complex_pkg::op_mult_l, complex_pkg::op_multu_l,
                   complex_pkg::op_div_l, complex_pkg::op_divu_l}) begin
      flg[complex_pkg::flg_lo_half] = 1'b1;
    end
    if (op == complex_pkg::op_syscall) begin
      flg[complex_pkg::flg_executed]  = 1'b1;
      flg[complex_pkg::flg_exception] = 1'b1;
    end
    return {res, flg};
  endfunction

  function automatic int assertion_failures();
    return u_complex_exec_lane.u_complex_exec_assertions.fail_cnt;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("MISMATCH %s: got %0h, expected %0h", name, got, want);
    end
  endtask

  // everything not yet written back dies with the flush edge
  task automatic drop_in_flight();
    while (exp_q.size() > 0 && exp_q[$].due > cyc) begin
      void'(exp_q.pop_back());
    end
  endtask

  task automatic issue(input logic [7:0] op, input logic [31:0] a, input logic [31:0] b,
                       input logic kill);
    wb_exp_t e;
    @(posedge clk);
    #1;
    issue_valid  = 1'b1;
    issue_opcode = op;
    issue_data1  = a;
    issue_data2  = b;
    issue_tag    = next_tag;
    flush        = kill;
    if (kill) begin
      drop_in_flight(); // same-cycle issue is not accepted
    end else begin
      {e.result, e.flags} = model_wb(op, a, b);
      e.tag = next_tag;
      e.due = cyc + LATENCY;
      exp_q.push_back(e);
    end
    next_tag = next_tag + 7'd1;
  endtask

  task automatic idle();
    @(posedge clk);
    #1;
    issue_valid = 1'b0;
    flush       = 1'b0;
  endtask

  task automatic drain();
    idle();
    while (exp_q.size() > 0) begin
      @(posedge clk);
    end
  endtask

  task automatic end_test(input string name);
    int fails;
    @(negedge clk);
    fails = errors + assertion_failures() - mark;
    mark  = mark + fails;
    tests_run++;
    if (fails > 0) begin
      tests_failed++;
    end
    $display("test %s: %0d failures", name, fails);
  endtask

  task automatic run_mult(input logic [7:0] op);
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        issue(op, edge_val(i), edge_val(j), 1'b0);
      end
    end
    repeat (6) begin
      issue(op, take_bits(32), take_bits(32), 1'b0);
    end
  endtask

  task automatic run_div(input logic [7:0] op);
    for (int i = 0; i < 6; i++) begin
      issue(op, take_bits(32), (i % 2 == 0) ? take_bits(32) : take_bits(9), 1'b0);
    end
    issue(op, take_bits(32), 32'd0, 1'b0); // divide by zero
    issue(op, 32'h8000_0000, 32'd0, 1'b0);
    issue(op, 32'h8000_0000, 32'hffff_ffff, 1'b0); // min / -1
  endtask

  // write-back monitor, mid-cycle so outputs are settled
  always @(negedge clk) begin : check_wb
    wb_exp_t e;
    if (arst_n && exp_q.size() > 0 && exp_q[0].due < cyc) begin
      errors++;
      $display("no write-back for tag %0h, due in cycle %0d", exp_q[0].tag, exp_q[0].due);
      void'(exp_q.pop_front());
    end
    if (arst_n && wb_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("write-back of tag %0h with nothing in flight", wb_tag);
      end else begin
        e = exp_q.pop_front();
        compare("wb_result_o", wb_result, e.result);
        compare("wb_flags_o", 32'(wb_flags), 32'(e.flags));
        compare("wb_tag_o", 32'(wb_tag), 32'(e.tag));
        compare("wb_valid_o cycle", cyc, e.due);
      end
    end
  end

  initial begin : watchdog
    while (cyc < max_cycles) begin
      @(posedge clk);
    end
    $display("timeout after %0d cycles, the test sequence did not finish", cyc);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin : main
    int total;
    arst_n       = 1'b0;
    issue_valid  = 1'b0;
    issue_opcode = '0;
    issue_data1  = '0;
    issue_data2  = '0;
    issue_tag    = '0;
    flush        = 1'b0;
    repeat (16) begin
      @(negedge clk);
      compare("wb_valid_o", 32'(wb_valid), 32'd0); // quiet under reset
    end
    @(posedge clk);
    #1;
    arst_n = 1'b1;
    repeat (6) begin
      idle(); // monitor flags any spurious write-back
    end
    issue(complex_pkg::op_multu_l, take_bits(32), take_bits(32), 1'b0);
    drain();
    end_test("reset");
    run_mult(complex_pkg::op_mult_l);
    run_mult(complex_pkg::op_mult_h);
    run_mult(complex_pkg::op_multu_l);
    run_mult(complex_pkg::op_multu_h);
    drain();
    end_test("multiply");
    run_div(complex_pkg::op_div_l);
    run_div(complex_pkg::op_div_h);
    run_div(complex_pkg::op_divu_l);
    run_div(complex_pkg::op_divu_h);
    drain();
    end_test("divide");
    repeat (3) begin
      issue(complex_pkg::op_syscall, take_bits(32), take_bits(32), 1'b0);
    end
    issue(8'h33, take_bits(32), take_bits(32), 1'b0);
    issue(8'h00, take_bits(32), take_bits(32), 1'b0);
    issue(8'hff, take_bits(32), take_bits(32), 1'b0);
    drain();
    end_test("syscall");
    for (int i = 0; i < 40; i++) begin
      issue(mix_op(4'(take_bits(4))), take_bits(32), take_bits(32), 1'b0);
    end
    drain();
    end_test("back_to_back");
    for (int i = 0; i < 3; i++) begin
      issue(mix_op(4'(take_bits(4))), take_bits(32), take_bits(32), 1'b0);
    end
    issue(complex_pkg::op_mult_l, take_bits(32), take_bits(32), 1'b1);
    repeat (LATENCY + 1) begin
      idle();
    end
    for (int i = 0; i < 3; i++) begin
      issue(mix_op(4'(take_bits(4))), take_bits(32), take_bits(32), 1'b0);
    end
    drain();
    end_test("flush");
    total = errors + assertion_failures();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, total);
    if (total == 0 && tests_failed == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
